// ==== all.f ====
+incdir+design
design/irq_ctrl_pkg.sv
design/irq_cfg_pkg.sv
design/irq_sync.sv
design/irq_cfg_regs.sv
design/interrupt_controller.sv
design/fetch_pc_unit.sv
design/irq_subsystem.sv
bench/irq_tb.sv

// ==== bench/irq_stimulus.txt ====
# kind arg_a arg_b expected, all hex; wr/rd: arg_a is cfg op, arg_b write data
# run: arg_a fetch-enabled cycles; entry: arg_a correct flag, arg_b corr_pc
rd    2   000 001
rd    3   000 000
state 0   000 0
run   a   000 00a
wr    0   200 000
wr    1   000 000
irq   0   000 000
rd    2   000 002
run   5   000 00f
wr    1   001 000
entry 0   000 200
rd    3   000 00f
state 0   000 2
run   3   000 203
ret   0   000 00f
state 0   000 0
run   6   000 015
corr  080 000 080
run   2   000 082
irq   0   000 000
entry 1   0c0 200
rd    3   000 0c0
ret   0   000 0c0
state 0   000 0
run   4   000 0c4
rd    2   000 001

// ==== bench/irq_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "irq_macros.svh"

module irq_tb;

    logic                           clk;
    logic                           nrst;
    logic                           irq_n;
    logic [`IRQ_OPCODE_WIDTH-1:0]   opcode;
    logic                           fetch_en;
    logic                           corr_valid;
    logic [`IRQ_PC_WIDTH-1:0]       corr_pc;
    logic                           cfg_req;
    irq_cfg_pkg::cfg_op_t           cfg_op;
    logic [`IRQ_PC_WIDTH-1:0]       cfg_wdata;
    logic                           cfg_ack;
    logic [`IRQ_PC_WIDTH-1:0]       cfg_rdata;
    logic [`IRQ_PC_WIDTH-1:0]       pc;
    logic                           stall;

    int                             value_errors;
    int                             timeout_errors;
    int                             other_errors;
    logic [31:0]                    lfsr;
    logic [`IRQ_PC_WIDTH-1:0]       model_pc;

    int                             fd;
    int                             nfields;
    int                             line_no;
    int                             drain_cnt;
    string                          line;
    string                          kind;
    string                          name;
    logic [`IRQ_PC_WIDTH-1:0]       arg_a;
    logic [`IRQ_PC_WIDTH-1:0]       arg_b;
    logic [`IRQ_PC_WIDTH-1:0]       expect_val;
    logic [`IRQ_PC_WIDTH-1:0]       rdata;

    irq_subsystem u_dut (
        .clk        (clk),
        .nrst       (nrst),
        .irq_n      (irq_n),
        .opcode     (opcode),
        .fetch_en   (fetch_en),
        .corr_valid (corr_valid),
        .corr_pc    (corr_pc),
        .cfg_req    (cfg_req),
        .cfg_op     (cfg_op),
        .cfg_wdata  (cfg_wdata),
        .cfg_ack    (cfg_ack),
        .cfg_rdata  (cfg_rdata),
        .pc         (pc),
        .stall      (stall)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // galois form, one step per random bit.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    task automatic random_bit(output logic b);
        b = lfsr[0];
        lfsr = lfsr_step(lfsr);
    endtask

    task automatic check_pc(input string tname, input logic [`IRQ_PC_WIDTH-1:0] exp,
                            input logic [`IRQ_PC_WIDTH-1:0] act);
        if (act !== exp) begin
            $display("FAILED %s pc expected %h actual %h", tname, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_rdata(input string tname, input logic [`IRQ_PC_WIDTH-1:0] exp,
                               input logic [`IRQ_PC_WIDTH-1:0] act);
        if (act !== exp) begin
            $display("FAILED %s rdata expected %h actual %h", tname, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_state(input string tname, input irq_ctrl_pkg::irq_state_t exp,
                               input irq_ctrl_pkg::irq_state_t act);
        if (act !== exp) begin
            $display("FAILED %s state expected %s actual %s", tname, exp.name(), act.name());
            value_errors++;
        end
    endtask

    task automatic check_count(input string tname, input int exp, input int act);
        if (act != exp) begin
            $display("FAILED %s drain cycles expected %0d actual %0d", tname, exp, act);
            value_errors++;
        end
    endtask

    // one four-phase transfer; fetch is held off so the pc model stays put.
    task automatic cfg_xfer(input string tname, input irq_cfg_pkg::cfg_op_t op,
                            input logic [`IRQ_PC_WIDTH-1:0] wdata,
                            output logic [`IRQ_PC_WIDTH-1:0] rd);
        int guard;
        guard = 0;
        fetch_en  = 1'b0;
        cfg_op    = op;
        cfg_wdata = wdata;
        cfg_req   = 1'b1;
        @(negedge clk);
        while (!cfg_ack && guard < 20) begin
            @(negedge clk);
            guard++;
        end
        rd = cfg_rdata;
        if (!cfg_ack) begin
            $display("%s: cfg_ack never rose after cfg_req", tname);
            timeout_errors++;
        end else begin
            // the acknowledge has to hold for as long as the request does.
            @(negedge clk);
            if (!cfg_ack) begin
                $display("%s: cfg_ack fell while cfg_req was still high", tname);
                other_errors++;
            end
        end
        cfg_req = 1'b0;
        guard = 0;
        @(negedge clk);
        while (cfg_ack && guard < 20) begin
            @(negedge clk);
            guard++;
        end
        if (cfg_ack) begin
            $display("%s: cfg_ack stayed high after cfg_req fell", tname);
            timeout_errors++;
        end
    endtask

    // issues n fetch-enabled cycles with random gaps in between.
    task automatic run_fetch(input string tname, input int n);
        int done;
        int guard;
        logic fe;
        done = 0;
        guard = 0;
        while (done < n && guard < 1000) begin
            random_bit(fe);
            fetch_en = fe;
            if (fe) begin
                done++;
                model_pc = model_pc + 1'b1;
            end
            @(negedge clk);
            guard++;
        end
        fetch_en = 1'b0;
        if (done < n) begin
            $display("%s: fetch cycles did not complete in time", tname);
            timeout_errors++;
        end
    endtask

    // counts fetch-enabled cycles while stall is high; can inject one correction.
    task automatic count_drain(input string tname, input logic do_corr,
                               input logic [`IRQ_PC_WIDTH-1:0] cpc, output int cnt);
        int guard;
        logic fe;
        logic first;
        cnt = 0;
        guard = 0;
        first = 1'b1;
        while (!stall && guard < 20) begin
            @(negedge clk);
            guard++;
        end
        if (!stall) begin
            $display("%s: stall never rose", tname);
            timeout_errors++;
        end
        guard = 0;
        while (stall && guard < 200) begin
            random_bit(fe);
            fetch_en   = fe;
            corr_valid = do_corr && first;
            corr_pc    = cpc;
            first = 1'b0;
            if (fe) begin
                cnt++;
            end
            @(negedge clk);
            guard++;
        end
        fetch_en   = 1'b0;
        corr_valid = 1'b0;
        if (stall) begin
            $display("%s: stall never fell", tname);
            timeout_errors++;
        end
    endtask

    initial begin
        value_errors   = 0;
        timeout_errors = 0;
        other_errors   = 0;
        lfsr       = 32'hdb37;
        model_pc   = '0;
        nrst       = 1'b0;
        irq_n      = 1'b1;
        opcode     = '0;
        fetch_en   = 1'b0;
        corr_valid = 1'b0;
        corr_pc    = '0;
        cfg_req    = 1'b0;
        cfg_op     = irq_cfg_pkg::op_read_status;
        cfg_wdata  = '0;
        line_no    = 0;

        repeat (8) @(negedge clk);
        nrst = 1'b1;
        @(negedge clk);
        check_pc("reset", '0, pc);

        fd = $fopen("bench/irq_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file");
            other_errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                line_no++;
                if (line.len() < 2 || line.substr(0, 0) == "#") begin
                    continue;
                end
                nfields = $sscanf(line, "%s %h %h %h", kind, arg_a, arg_b, expect_val);
                if (nfields != 4) begin
                    $display("line %0d of the stimulus file is malformed", line_no);
                    other_errors++;
                    continue;
                end
                name = $sformatf("line %0d %s", line_no, kind);

                if (kind == "wr") begin
                    cfg_xfer(name, irq_cfg_pkg::cfg_op_t'(arg_a[1:0]), arg_b, rdata);
                end else if (kind == "rd") begin
                    cfg_xfer(name, irq_cfg_pkg::cfg_op_t'(arg_a[1:0]), '0, rdata);
                    check_rdata(name, expect_val, rdata);
                end else if (kind == "state") begin
                    cfg_xfer(name, irq_cfg_pkg::op_read_status, '0, rdata);
                    check_state(name, irq_ctrl_pkg::irq_state_t'(expect_val[1:0]),
                                irq_ctrl_pkg::irq_state_t'(rdata[3:2]));
                end else if (kind == "run") begin
                    run_fetch(name, int'(arg_a));
                    check_pc(name, expect_val, pc);
                    if (model_pc !== expect_val) begin
                        $display("%s: pc model and stimulus file disagree", name);
                        other_errors++;
                    end
                end else if (kind == "irq") begin
                    fetch_en = 1'b0;
                    irq_n = 1'b0;
                    repeat (4) @(negedge clk);
                    irq_n = 1'b1;
                    @(negedge clk);
                end else if (kind == "corr") begin
                    fetch_en   = 1'b1;
                    corr_valid = 1'b1;
                    corr_pc    = arg_a;
                    @(negedge clk);
                    fetch_en   = 1'b0;
                    corr_valid = 1'b0;
                    model_pc   = arg_a;
                    check_pc(name, expect_val, pc);
                end else if (kind == "entry" || kind == "ret") begin
                    if (kind == "ret") begin
                        opcode   = `IRQ_OPC_SYSTEM;
                        fetch_en = 1'b1;
                        @(negedge clk);
                        opcode   = '0;
                        fetch_en = 1'b0;
                    end
                    count_drain(name, arg_a[0], arg_b, drain_cnt);
                    check_count(name, `IRQ_DRAIN_CYCLES, drain_cnt);
                    // the redirect lands on the edge after stall falls.
                    @(negedge clk);
                    check_pc(name, expect_val, pc);
                    model_pc = expect_val;
                end else begin
                    $display("unknown step kind on line %0d of the stimulus file", line_no);
                    other_errors++;
                end
            end
            $fclose(fd);
        end

        $display("errors: %0d value, %0d timeout, %0d other",
                 value_errors, timeout_errors, other_errors);
        if (value_errors + timeout_errors + other_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/fetch_pc_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "irq_macros.svh"

module fetch_pc_unit (
    input  logic                        clk,
    input  logic                        nrst,
    input  logic                        fetch_en,
    input  logic                        stall,
    input  logic                        sel_isr,
    input  logic                        ret_isr,
    input  logic [`IRQ_PC_WIDTH-1:0]    isr_vector,
    input  logic [`IRQ_PC_WIDTH-1:0]    save_pc,
    input  logic                        corr_valid,
    input  logic [`IRQ_PC_WIDTH-1:0]    corr_pc,
    output logic [`IRQ_PC_WIDTH-1:0]    pc
);

    localparam logic [`IRQ_PC_WIDTH-1:0] pc_step = 1;

    // the redirect pulses come once per drain and must never be dropped,
    // so they load pc whether or not fetch is enabled in that cycle.
    // everything else waits for fetch_en.
    always_ff @(posedge clk) begin
        if (!nrst) begin
            pc <= '0;
        end else if (sel_isr) begin
            pc <= isr_vector;
        end else if (ret_isr) begin
            pc <= save_pc;
        end else if (stall) begin
            // hold while the pipeline drains.
            pc <= pc;
        end else if (fetch_en) begin
            if (corr_valid) begin
                pc <= corr_pc;
            end else begin
                pc <= pc + pc_step;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/interrupt_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "irq_macros.svh"

module interrupt_controller (
    input  logic                            clk,
    input  logic                            nrst,
    input  logic                            irq_pending,
    input  logic                            irq_enable,
    input  logic [`IRQ_PC_WIDTH-1:0]        pc,
    input  logic [`IRQ_OPCODE_WIDTH-1:0]    opcode,
    input  logic                            fetch_en,
    input  logic                            corr_valid,
    input  logic [`IRQ_PC_WIDTH-1:0]        corr_pc,
    output logic                            irq_taken,
    output logic                            stall,
    output logic                            sel_isr,
    output logic                            ret_isr,
    output logic [`IRQ_PC_WIDTH-1:0]        save_pc,
    output irq_ctrl_pkg::irq_state_t        state
);

    localparam logic [2:0] drain_last = 3'(`IRQ_DRAIN_CYCLES - 1);

    logic [2:0] drain_cnt;
    logic       in_drain;
    logic       drain_done;
    logic       ret_op;

    assign in_drain = (state == irq_ctrl_pkg::st_drain_entry) ||
                      (state == irq_ctrl_pkg::st_drain_return);

    // the drain only counts cycles in which fetch actually moved.
    assign drain_done = in_drain && fetch_en && (drain_cnt == drain_last);

    assign ret_op = fetch_en && (opcode == `IRQ_OPC_SYSTEM);

    always_ff @(posedge clk) begin
        if (!nrst) begin
            drain_cnt <= '0;
        end else if (drain_done) begin
            drain_cnt <= '0;
        end else if (in_drain && fetch_en) begin
            drain_cnt <= drain_cnt + 3'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            state     <= irq_ctrl_pkg::st_idle;
            stall     <= 1'b0;
            sel_isr   <= 1'b0;
            ret_isr   <= 1'b0;
            irq_taken <= 1'b0;
            save_pc   <= '0;
        end else begin
            // the three strobes are single-cycle unless a branch below sets them.
            irq_taken <= 1'b0;
            sel_isr   <= 1'b0;
            ret_isr   <= 1'b0;

            case (state)
                irq_ctrl_pkg::st_idle: begin
                    // pc is still being restored while ret_isr is high.
                    if (irq_pending && irq_enable && !ret_isr) begin
                        state     <= irq_ctrl_pkg::st_drain_entry;
                        save_pc   <= pc;
                        irq_taken <= 1'b1;
                        stall     <= 1'b1;
                    end
                end

                irq_ctrl_pkg::st_drain_entry: begin
                    // a branch resolved by an older instruction moves the return point.
                    if (corr_valid) begin
                        save_pc <= corr_pc;
                    end
                    if (drain_done) begin
                        state   <= irq_ctrl_pkg::st_in_isr;
                        stall   <= 1'b0;
                        sel_isr <= 1'b1;
                    end
                end

                irq_ctrl_pkg::st_in_isr: begin
                    if (ret_op) begin
                        state <= irq_ctrl_pkg::st_drain_return;
                        stall <= 1'b1;
                    end
                end

                irq_ctrl_pkg::st_drain_return: begin
                    if (drain_done) begin
                        state   <= irq_ctrl_pkg::st_idle;
                        stall   <= 1'b0;
                        ret_isr <= 1'b1;
                    end
                end

                default: begin
                    state <= irq_ctrl_pkg::st_idle;
                    stall <= 1'b0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/irq_cfg_pkg.sv ====
`default_nettype none

package irq_cfg_pkg;

    // operations carried on the configuration request/acknowledge bus.
    // the two writes take their data from cfg_wdata.
    // the two reads return their result on cfg_rdata with the acknowledge.
    typedef enum logic [1:0] {
        op_write_vector = 2'd0,
        op_write_enable = 2'd1,
        op_read_status  = 2'd2,
        op_read_save_pc = 2'd3
    } cfg_op_t;

endpackage

`default_nettype wire

// ==== design/irq_cfg_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "irq_macros.svh"

module irq_cfg_regs (
    input  logic                          clk,
    input  logic                          nrst,
    input  logic                          cfg_req,
    input  irq_cfg_pkg::cfg_op_t          cfg_op,
    input  logic [`IRQ_PC_WIDTH-1:0]      cfg_wdata,
    output logic                          cfg_ack,
    output logic [`IRQ_PC_WIDTH-1:0]      cfg_rdata,
    input  logic                          irq_pending,
    input  irq_ctrl_pkg::irq_state_t      state,
    input  logic [`IRQ_PC_WIDTH-1:0]      save_pc,
    output logic                          irq_enable,
    output logic [`IRQ_PC_WIDTH-1:0]      isr_vector
);

    // acknowledge side of the four-phase handshake.
    typedef enum logic {
        hs_wait_req,
        hs_wait_release
    } hs_state_t;

    hs_state_t                  hs_state;
    logic                       accept;
    logic [`IRQ_PC_WIDTH-1:0]   status_word;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            hs_state <= hs_wait_req;
        end else begin
            case (hs_state)
                hs_wait_req:     if (cfg_req) hs_state <= hs_wait_release;
                hs_wait_release: if (!cfg_req) hs_state <= hs_wait_req;
                default:         hs_state <= hs_wait_req;
            endcase
        end
    end

    assign cfg_ack = (hs_state == hs_wait_release);

    // each request is executed once, on the edge that first sees it.
    assign accept = cfg_req && (hs_state == hs_wait_req);

    // status layout is enable in bit 0, pending in bit 1 and the sequencer state above.
    assign status_word = {{(`IRQ_PC_WIDTH-4){1'b0}}, state, irq_pending, irq_enable};

    always_ff @(posedge clk) begin
        if (!nrst) begin
            isr_vector <= `IRQ_RESET_VECTOR;
            irq_enable <= 1'b1;
        end else if (accept) begin
            case (cfg_op)
                irq_cfg_pkg::op_write_vector: isr_vector <= cfg_wdata;
                irq_cfg_pkg::op_write_enable: irq_enable <= cfg_wdata[0];
                default:                      ;
            endcase
        end
    end

    // read data is valid from the first acknowledged cycle until the next request.
    always_ff @(posedge clk) begin
        if (accept) begin
            case (cfg_op)
                irq_cfg_pkg::op_read_status:  cfg_rdata <= status_word;
                irq_cfg_pkg::op_read_save_pc: cfg_rdata <= save_pc;
                default:                      cfg_rdata <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== design/irq_ctrl_pkg.sv ====
`default_nettype none

package irq_ctrl_pkg;

    // states of the interrupt entry and return sequencer.
    // st_idle runs normal fetch and waits for an accepted interrupt.
    // st_drain_entry holds fetch while older instructions leave the pipeline.
    // st_in_isr runs the handler until a SYSTEM opcode is fetched.
    // st_drain_return empties the pipeline again before going back.
    typedef enum logic [1:0] {
        st_idle         = 2'd0,
        st_drain_entry  = 2'd1,
        st_in_isr       = 2'd2,
        st_drain_return = 2'd3
    } irq_state_t;

endpackage

`default_nettype wire

// ==== design/irq_macros.svh ====
`ifndef IRQ_MACROS_SVH
`define IRQ_MACROS_SVH

// width of the fetch program counter and of every address that follows it.
`define IRQ_PC_WIDTH 12

// fetch-enabled cycles the pipeline needs to empty before a redirect.
`define IRQ_DRAIN_CYCLES 4

// width of the opcode field seen at fetch.
`define IRQ_OPCODE_WIDTH 7

// the SYSTEM major opcode ends the interrupt service routine.
`define IRQ_OPC_SYSTEM 7'h73

// vector used until software writes a new one.
`define IRQ_RESET_VECTOR 12'h100

`endif

// ==== design/irq_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "irq_macros.svh"

module irq_subsystem (
    input  logic                            clk,
    input  logic                            nrst,
    input  logic                            irq_n,
    input  logic [`IRQ_OPCODE_WIDTH-1:0]    opcode,
    input  logic                            fetch_en,
    input  logic                            corr_valid,
    input  logic [`IRQ_PC_WIDTH-1:0]        corr_pc,
    input  logic                            cfg_req,
    input  irq_cfg_pkg::cfg_op_t            cfg_op,
    input  logic [`IRQ_PC_WIDTH-1:0]        cfg_wdata,
    output logic                            cfg_ack,
    output logic [`IRQ_PC_WIDTH-1:0]        cfg_rdata,
    output logic [`IRQ_PC_WIDTH-1:0]        pc,
    output logic                            stall
);

    logic                           irq_pending;
    logic                           irq_taken;
    logic                           irq_enable;
    logic [`IRQ_PC_WIDTH-1:0]       isr_vector;
    logic                           sel_isr;
    logic                           ret_isr;
    logic [`IRQ_PC_WIDTH-1:0]       save_pc;
    irq_ctrl_pkg::irq_state_t       state;

    irq_sync u_sync (
        .clk         (clk),
        .nrst        (nrst),
        .irq_n       (irq_n),
        .irq_taken   (irq_taken),
        .irq_pending (irq_pending)
    );

    irq_cfg_regs u_cfg (
        .clk         (clk),
        .nrst        (nrst),
        .cfg_req     (cfg_req),
        .cfg_op      (cfg_op),
        .cfg_wdata   (cfg_wdata),
        .cfg_ack     (cfg_ack),
        .cfg_rdata   (cfg_rdata),
        .irq_pending (irq_pending),
        .state       (state),
        .save_pc     (save_pc),
        .irq_enable  (irq_enable),
        .isr_vector  (isr_vector)
    );

    interrupt_controller u_ctrl (
        .clk         (clk),
        .nrst        (nrst),
        .irq_pending (irq_pending),
        .irq_enable  (irq_enable),
        .pc          (pc),
        .opcode      (opcode),
        .fetch_en    (fetch_en),
        .corr_valid  (corr_valid),
        .corr_pc     (corr_pc),
        .irq_taken   (irq_taken),
        .stall       (stall),
        .sel_isr     (sel_isr),
        .ret_isr     (ret_isr),
        .save_pc     (save_pc),
        .state       (state)
    );

    fetch_pc_unit u_pc (
        .clk         (clk),
        .nrst        (nrst),
        .fetch_en    (fetch_en),
        .stall       (stall),
        .sel_isr     (sel_isr),
        .ret_isr     (ret_isr),
        .isr_vector  (isr_vector),
        .save_pc     (save_pc),
        .corr_valid  (corr_valid),
        .corr_pc     (corr_pc),
        .pc          (pc)
    );

endmodule

`default_nettype wire

// ==== design/irq_sync.sv ====
`timescale 1ns/1ps
`default_nettype none

module irq_sync (
    input  logic clk,
    input  logic nrst,
    input  logic irq_n,
    input  logic irq_taken,
    output logic irq_pending
);

    // the pin is asynchronous, so it passes two flops before any logic sees it.
    logic sync_meta;
    logic sync_q;
    logic sync_last;
    logic irq_fall;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            sync_meta <= 1'b1;
            sync_q    <= 1'b1;
            sync_last <= 1'b1;
        end else begin
            sync_meta <= irq_n;
            sync_q    <= sync_meta;
            sync_last <= sync_q;
        end
    end

    // only the high-to-low transition requests service.
    assign irq_fall = sync_last && !sync_q;

    // a fresh edge in the same cycle as the acknowledge keeps the request alive.
    always_ff @(posedge clk) begin
        if (!nrst) begin
            irq_pending <= 1'b0;
        end else if (irq_fall) begin
            irq_pending <= 1'b1;
        end else if (irq_taken) begin
            irq_pending <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the interrupt subsystem testbench with Verilator and runs it.
# The simulator output goes to sim.log, which is then searched for the fail banner.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module irq_tb -f all.f -o irq_sim \
    && ./obj_dir/irq_sim > sim.log 2>&1 \
    || { echo "build or simulation did not complete"; exit 1; }

grep -q "=== FAIL ===" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "=== PASS ===" sim.log || { echo "simulation ended without a verdict"; exit 1; }
echo "simulation passed"
exit 0
